// File: source/ualink_config.svh
// ##########################################################################
// UALink turbo configuration macros
// widths, FIFO depth, burst length and command opcodes
// ##########################################################################
`ifndef UALINK_CONFIG_SVH
`define UALINK_CONFIG_SVH

`define UALINK_DATA_W          64   // stream and memory word
`define UALINK_ADDR_W          8    // 256-entry data memory
`define UALINK_FIFO_DEPTH_BITS 4    // 16-entry input FIFO
`define UALINK_BURST_WORDS     8    // 64B per write or read

// header opcodes, bits 63:48 of the header word
`define UALINK_OP_WRITE        16'h0245
`define UALINK_OP_READ         16'h0145

`endif

// File: source/ualink_pkg.sv
// ##########################################################################
// UALink turbo package
// shared word and address types, FSM state encodings
// ##########################################################################
`default_nettype none

`include "ualink_config.svh"

package ualink_pkg;

   typedef logic [`UALINK_DATA_W-1:0] data_t;      // one stream or memory word
   typedef logic [`UALINK_ADDR_W-1:0] mem_addr_t;  // data memory address
   typedef logic [15:0]               opcode_t;    // header opcode field
   typedef logic [3:0]                burst_cnt_t; // word index within a burst

   // command parser FSM
   typedef enum logic [1:0] {PS_IDLE, PS_FWD, PS_WRITE, PS_READ_WAIT} parser_state_t;

   // response generator FSM
   typedef enum logic [1:0] {RS_PASS, RS_FETCH, RS_SEND} rsp_state_t;

endpackage

`default_nettype wire

// File: source/ualink_stream_if.sv
// ##########################################################################
// UALink internal stream link, AXI4-Stream style valid/ready handshake
// ##########################################################################
`timescale 1ns/1ns
`default_nettype none

interface ualink_stream_if;
   import ualink_pkg::*;

   data_t data;
   logic  last;
   logic  valid;
   logic  ready;

   modport producer (output data, output last, output valid, input ready);
   modport consumer (input data, input last, input valid, output ready);

endinterface

`default_nettype wire

// File: source/ualink_rx_fifo.sv
// ##########################################################################
// UALink input FIFO, 16 words deep with fall-through head
// stores each word with its last flag
// ##########################################################################
`timescale 1ns/1ns
`default_nettype none

`include "ualink_config.svh"

module ualink_rx_fifo (
   input  logic             axi_aclk,
   input  logic             axi_resetn,
   input  ualink_pkg::data_t s_data,
   input  logic             s_last,
   input  logic             s_valid,
   output logic             s_ready,
   ualink_stream_if.producer q
);
   import ualink_pkg::*;

   localparam logic [`UALINK_FIFO_DEPTH_BITS:0] fifo_depth =
      {1'b1, {`UALINK_FIFO_DEPTH_BITS{1'b0}}};

   data_t buf_data [0:fifo_depth-1];
   logic  buf_last [0:fifo_depth-1];

   logic [`UALINK_FIFO_DEPTH_BITS-1:0] wr_ptr;
   logic [`UALINK_FIFO_DEPTH_BITS-1:0] rd_ptr;
   logic [`UALINK_FIFO_DEPTH_BITS:0]   count;   // occupancy, 0..16
   logic wr_en;
   logic rd_en;

   assign s_ready = (count != fifo_depth);
   assign wr_en   = s_valid & s_ready;
   assign rd_en   = q.valid & q.ready;

   // head of queue is visible without a read cycle
   assign q.data  = buf_data[rd_ptr];
   assign q.last  = buf_last[rd_ptr];
   assign q.valid = (count != '0);

   always_ff @(posedge axi_aclk) begin
      if (wr_en) begin
         buf_data[wr_ptr] <= s_data;
         buf_last[wr_ptr] <= s_last;
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) wr_ptr <= wr_ptr + 1'b1;
         if (rd_en) rd_ptr <= rd_ptr + 1'b1;
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // both or neither
         endcase
      end
   end

endmodule

`default_nettype wire

// File: source/ualink_data_mem.sv
// ##########################################################################
// UALink data memory, 256 x 64 bits
// write port A, registered read port B
// ##########################################################################
`timescale 1ns/1ns
`default_nettype none

`include "ualink_config.svh"

module ualink_data_mem (
   input  logic                  axi_aclk,
   input  logic                  mem_we,
   input  ualink_pkg::mem_addr_t mem_waddr,
   input  ualink_pkg::data_t     mem_wdata,
   input  ualink_pkg::mem_addr_t mem_raddr,
   output ualink_pkg::data_t     mem_rdata
);
   import ualink_pkg::*;

   data_t mem [0:(1 << `UALINK_ADDR_W)-1];

   always_ff @(posedge axi_aclk) begin
      if (mem_we) mem[mem_waddr] <= mem_wdata;
   end

   // read data lands one cycle after the address
   always_ff @(posedge axi_aclk) begin
      mem_rdata <= mem[mem_raddr];
   end

endmodule

`default_nettype wire

// File: source/ualink_cmd_parser.sv
// ##########################################################################
// UALink command parser
// forwards frames, writes payload bursts, requests read bursts
// ##########################################################################
`timescale 1ns/1ns
`default_nettype none

`include "ualink_config.svh"

module ualink_cmd_parser (
   input  logic                  axi_aclk,
   input  logic                  axi_resetn,
   ualink_stream_if.consumer     in_q,
   ualink_stream_if.producer     out_s,
   output logic                  mem_we,
   output ualink_pkg::mem_addr_t mem_waddr,
   output ualink_pkg::data_t     mem_wdata,
   output logic                  rd_start,
   output ualink_pkg::mem_addr_t rd_addr,
   input  logic                  rd_done
);
   import ualink_pkg::*;

   parser_state_t state;
   parser_state_t state_next;
   mem_addr_t     base_addr;    // write burst base
   burst_cnt_t    burst_cnt;
   opcode_t       hdr_opcode;
   logic          xfer;
   logic          is_read;
   logic          is_write;
   logic          burst_end;

   assign hdr_opcode = in_q.data[`UALINK_DATA_W-1 -: 16];
   assign is_read    = (hdr_opcode == `UALINK_OP_READ);
   assign is_write   = (hdr_opcode == `UALINK_OP_WRITE);
   assign burst_end  = (burst_cnt == burst_cnt_t'(`UALINK_BURST_WORDS - 1));

   // straight forwarding, held off while a read burst is out
   assign out_s.valid = in_q.valid & (state != PS_READ_WAIT);
   assign out_s.data  = in_q.data;
   assign out_s.last  = (state == PS_IDLE && is_read) ? 1'b0 : in_q.last;
   assign in_q.ready  = out_s.ready & (state != PS_READ_WAIT);
   assign xfer        = in_q.valid & in_q.ready;

   // payload words go to memory as they pass
   assign mem_we    = (state == PS_WRITE) & xfer;
   assign mem_waddr = base_addr + mem_addr_t'(burst_cnt);
   assign mem_wdata = in_q.data;

   assign rd_start = (state == PS_IDLE) & xfer & is_read;
   assign rd_addr  = in_q.data[`UALINK_ADDR_W-1:0];

   always_comb begin
      state_next = state;
      case (state)
         PS_IDLE: begin
            if (xfer) begin
               if (is_read)                      state_next = PS_READ_WAIT;
               else if (is_write && !in_q.last)  state_next = PS_WRITE;
               else if (!in_q.last)              state_next = PS_FWD;
            end
         end
         PS_WRITE: begin
            if (xfer && in_q.last) state_next = PS_IDLE;
            else if (xfer && burst_end) state_next = PS_FWD;  // rest is echo only
         end
         PS_FWD: begin
            if (xfer && in_q.last) state_next = PS_IDLE;
         end
         PS_READ_WAIT: begin
            if (rd_done) state_next = PS_IDLE;
         end
         default: state_next = PS_IDLE;
      endcase
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         state     <= PS_IDLE;
         burst_cnt <= '0;
      end else begin
         state <= state_next;
         if (state == PS_IDLE) burst_cnt <= '0;
         else if (mem_we) burst_cnt <= burst_cnt + 1'b1;
      end
   end

   // address byte of the header, only meaningful for writes
   always_ff @(posedge axi_aclk) begin
      if (state == PS_IDLE && xfer) base_addr <= in_q.data[`UALINK_ADDR_W-1:0];
   end

endmodule

`default_nettype wire

// File: source/ualink_rsp_gen.sv
// ##########################################################################
// UALink response generator
// merges forwarded words with 8-word read bursts from the data memory
// ##########################################################################
`timescale 1ns/1ns
`default_nettype none

`include "ualink_config.svh"

module ualink_rsp_gen (
   input  logic                  axi_aclk,
   input  logic                  axi_resetn,
   ualink_stream_if.consumer     in_s,
   input  logic                  rd_start,
   input  ualink_pkg::mem_addr_t rd_addr,
   output logic                  rd_done,
   output ualink_pkg::mem_addr_t mem_raddr,
   input  ualink_pkg::data_t     mem_rdata,
   output ualink_pkg::data_t     m_data,
   output logic                  m_last,
   output logic                  m_valid,
   input  logic                  m_ready
);
   import ualink_pkg::*;

   rsp_state_t state;
   mem_addr_t  base_addr;
   burst_cnt_t word_cnt;
   logic       last_word;
   logic       send_xfer;

   assign last_word = (word_cnt == burst_cnt_t'(`UALINK_BURST_WORDS - 1));
   assign send_xfer = (state == RS_SEND) & m_ready;

   // address stays put through RS_SEND, so the memory read register
   // holds the burst word until it is taken
   assign mem_raddr = base_addr + mem_addr_t'(word_cnt);

   always_comb begin
      if (state == RS_PASS) begin
         m_data  = in_s.data;
         m_last  = in_s.last;
         m_valid = in_s.valid;
      end else begin
         m_data  = mem_rdata;
         m_last  = last_word;
         m_valid = (state == RS_SEND);   // low while fetching
      end
   end

   assign in_s.ready = (state == RS_PASS) & m_ready;
   assign rd_done    = send_xfer & last_word;

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         state    <= RS_PASS;
         word_cnt <= '0;
      end else begin
         case (state)
            RS_PASS: begin
               if (rd_start) begin
                  state    <= RS_FETCH;
                  word_cnt <= '0;
               end
            end
            RS_FETCH: state <= RS_SEND;   // read data valid next cycle
            RS_SEND: begin
               if (send_xfer) begin
                  if (last_word) begin
                     state <= RS_PASS;
                  end else begin
                     state    <= RS_FETCH;
                     word_cnt <= word_cnt + 1'b1;
                  end
               end
            end
            default: state <= RS_PASS;
         endcase
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (state == RS_PASS && rd_start) base_addr <= rd_addr;
   end

endmodule

`default_nettype wire

// File: source/ualink_turbo.sv
// ##########################################################################
// UALink turbo top level
// input FIFO, command parser, data memory and response generator
// ##########################################################################
`timescale 1ns/1ns
`default_nettype none

module ualink_turbo (
   input  logic              axi_aclk,
   input  logic              axi_resetn,
   input  ualink_pkg::data_t s_axis_tdata,
   input  logic              s_axis_tlast,
   input  logic              s_axis_tvalid,
   output logic              s_axis_tready,
   output ualink_pkg::data_t m_axis_tdata,
   output logic              m_axis_tlast,
   output logic              m_axis_tvalid,
   input  logic              m_axis_tready
);
   import ualink_pkg::*;

   ualink_stream_if fifo_q ();   // FIFO head to parser
   ualink_stream_if fwd_s ();    // parser to output merge

   logic      mem_we;
   mem_addr_t mem_waddr;
   data_t     mem_wdata;
   mem_addr_t mem_raddr;
   data_t     mem_rdata;
   logic      rd_start;
   mem_addr_t rd_addr;
   logic      rd_done;

   ualink_rx_fifo u_rx_fifo (
      .axi_aclk   (axi_aclk),
      .axi_resetn (axi_resetn),
      .s_data     (s_axis_tdata),
      .s_last     (s_axis_tlast),
      .s_valid    (s_axis_tvalid),
      .s_ready    (s_axis_tready),
      .q          (fifo_q.producer)
   );

   ualink_cmd_parser u_cmd_parser (
      .axi_aclk   (axi_aclk),
      .axi_resetn (axi_resetn),
      .in_q       (fifo_q.consumer),
      .out_s      (fwd_s.producer),
      .mem_we     (mem_we),
      .mem_waddr  (mem_waddr),
      .mem_wdata  (mem_wdata),
      .rd_start   (rd_start),
      .rd_addr    (rd_addr),
      .rd_done    (rd_done)
   );

   ualink_data_mem u_data_mem (
      .axi_aclk  (axi_aclk),
      .mem_we    (mem_we),
      .mem_waddr (mem_waddr),
      .mem_wdata (mem_wdata),
      .mem_raddr (mem_raddr),
      .mem_rdata (mem_rdata)
   );

   ualink_rsp_gen u_rsp_gen (
      .axi_aclk   (axi_aclk),
      .axi_resetn (axi_resetn),
      .in_s       (fwd_s.consumer),
      .rd_start   (rd_start),
      .rd_addr    (rd_addr),
      .rd_done    (rd_done),
      .mem_raddr  (mem_raddr),
      .mem_rdata  (mem_rdata),
      .m_data     (m_axis_tdata),
      .m_last     (m_axis_tlast),
      .m_valid    (m_axis_tvalid),
      .m_ready    (m_axis_tready)
   );

endmodule

`default_nettype wire

// File: testbench/ualink_turbo_tb.sv
// ##########################################################################
// UALink turbo testbench
// table of command frames checked against a memory model, with back-pressure
// ##########################################################################
`timescale 1ns/1ns
`default_nettype none

`include "ualink_config.svh"

module ualink_turbo_tb;
   import ualink_pkg::*;

   localparam int NUM_TESTS = 14;

   logic  axi_aclk;
   logic  axi_resetn;
   data_t s_axis_tdata;
   logic  s_axis_tlast;
   logic  s_axis_tvalid;
   logic  s_axis_tready;
   data_t m_axis_tdata;
   logic  m_axis_tlast;
   logic  m_axis_tvalid;
   logic  m_axis_tready;

   // stimulus table, one command frame per row
   string       test_name [NUM_TESTS];
   opcode_t     tbl_op    [NUM_TESTS];
   mem_addr_t   tbl_addr  [NUM_TESTS];
   int          tbl_len   [NUM_TESTS];   // payload words after the header
   logic [31:0] tbl_seed  [NUM_TESTS];
   logic        tbl_bp    [NUM_TESTS];   // random m_axis_tready

   data_t model_mem [256];
   data_t in_data  [$];
   logic  in_last  [$];
   data_t exp_data [$];
   logic  exp_last [$];
   int    exp_idx  [$];   // table row of each expected word
   int    exp_pos  [$];   // word number within its frame

   int          check_errors;
   int          other_errors;
   logic [31:0] lcg_state;
   logic        in_xfer;

   ualink_turbo u_ualink_turbo (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .s_axis_tdata  (s_axis_tdata),
      .s_axis_tlast  (s_axis_tlast),
      .s_axis_tvalid (s_axis_tvalid),
      .s_axis_tready (s_axis_tready),
      .m_axis_tdata  (m_axis_tdata),
      .m_axis_tlast  (m_axis_tlast),
      .m_axis_tvalid (m_axis_tvalid),
      .m_axis_tready (m_axis_tready)
   );

   initial begin
      axi_aclk = 1'b0;
      forever #50 axi_aclk = ~axi_aclk;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1103515245 + 32'd12345;
   endfunction

   task automatic set_entry(input int i, input string name, input opcode_t op,
                            input mem_addr_t addr, input int len,
                            input logic [31:0] seed, input logic bp);
      test_name[i] = name;
      tbl_op[i]    = op;
      tbl_addr[i]  = addr;
      tbl_len[i]   = len;
      tbl_seed[i]  = seed;
      tbl_bp[i]    = bp;
   endtask

   task automatic push_input(input data_t d, input logic l);
      in_data.push_back(d);
      in_last.push_back(l);
   endtask

   task automatic push_expect(input data_t d, input logic l, input int i, input int pos);
      exp_data.push_back(d);
      exp_last.push_back(l);
      exp_idx.push_back(i);
      exp_pos.push_back(pos);
   endtask

   // expected output of one frame, and the memory model after it
   task automatic build_frame(input int i);
      data_t     hdr;
      data_t     w;
      mem_addr_t a;
      int        k;
      hdr = {tbl_op[i], 8'h00, tbl_seed[i], tbl_addr[i]};
      push_input(hdr, tbl_len[i] == 0);
      if (tbl_op[i] == `UALINK_OP_READ) begin
         push_expect(hdr, 1'b0, i, 0);   // tlast moves to the burst
         for (k = 0; k < `UALINK_BURST_WORDS; k++) begin
            a = tbl_addr[i] + mem_addr_t'(k);   // wraps modulo 256
            push_expect(model_mem[a], k == `UALINK_BURST_WORDS - 1, i, k + 1);
         end
      end else begin
         push_expect(hdr, tbl_len[i] == 0, i, 0);
         for (k = 0; k < tbl_len[i]; k++) begin
            w = {tbl_seed[i], 16'hC0DE, 16'(k)};
            push_input(w, k == tbl_len[i] - 1);
            push_expect(w, k == tbl_len[i] - 1, i, k + 1);
            if (tbl_op[i] == `UALINK_OP_WRITE && k < `UALINK_BURST_WORDS) begin
               a = tbl_addr[i] + mem_addr_t'(k);
               model_mem[a] = w;   // only the first burst reaches memory
            end
         end
      end
   endtask

   task automatic check_data(input string name, input data_t expected, input data_t actual);
      if (actual !== expected) begin
         $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
         check_errors++;
      end
   endtask

   task automatic check_last(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
         check_errors++;
      end
   endtask

   initial begin
      int    cycles;
      int    limit;
      int    drain;
      int    full_cycles;
      logic  timed_out;
      string name;
      axi_resetn    = 1'b0;
      s_axis_tdata  = '0;
      s_axis_tlast  = 1'b0;
      s_axis_tvalid = 1'b0;
      m_axis_tready = 1'b0;
      check_errors  = 0;
      other_errors  = 0;
      lcg_state     = 32'd20696;
      in_xfer       = 1'b0;
      cycles        = 0;
      drain         = 0;
      full_cycles   = 0;
      timed_out     = 1'b0;

      set_entry(0,  "pass_through",    16'h1234,         8'h10, 3,  32'h0000_0011, 1'b0);
      set_entry(1,  "write_echo",      `UALINK_OP_WRITE, 8'h20, 8,  32'h0000_0022, 1'b0);
      set_entry(2,  "read_back",       `UALINK_OP_READ,  8'h20, 0,  32'h0000_0033, 1'b0);
      set_entry(3,  "write_wrap",      `UALINK_OP_WRITE, 8'hFC, 8,  32'h0000_0044, 1'b0);
      set_entry(4,  "read_wrap",       `UALINK_OP_READ,  8'hFC, 0,  32'h0000_0055, 1'b0);
      set_entry(5,  "pre_fill",        `UALINK_OP_WRITE, 8'h48, 8,  32'h0000_0066, 1'b0);
      set_entry(6,  "long_write",      `UALINK_OP_WRITE, 8'h40, 10, 32'h0000_0077, 1'b0);
      set_entry(7,  "long_read",       `UALINK_OP_READ,  8'h42, 0,  32'h0000_0088, 1'b0);
      set_entry(8,  "bp_pass_through", 16'h00A7,         8'h05, 12, 32'h0000_0099, 1'b1);
      set_entry(9,  "bp_write_echo",   `UALINK_OP_WRITE, 8'h80, 8,  32'h0000_00AA, 1'b1);
      set_entry(10, "bp_read_back",    `UALINK_OP_READ,  8'h80, 0,  32'h0000_00BB, 1'b1);
      set_entry(11, "bp_long_write",   `UALINK_OP_WRITE, 8'h7C, 10, 32'h0000_00CC, 1'b1);
      set_entry(12, "bp_read_wrap",    `UALINK_OP_READ,  8'hFC, 0,  32'h0000_00DD, 1'b1);
      set_entry(13, "bp_long_read",    `UALINK_OP_READ,  8'h7E, 0,  32'h0000_00EE, 1'b1);
      for (int i = 0; i < NUM_TESTS; i++) build_frame(i);
      limit = 20 * exp_data.size() + 200;

      repeat (3) @(posedge axi_aclk);
      axi_resetn <= 1'b1;
      @(negedge axi_aclk);
      check_last("reset_tvalid", 1'b0, m_axis_tvalid);
      check_last("reset_tready", 1'b1, s_axis_tready);

      // drive on the rising edge, sample on the falling edge
      while (!timed_out && drain < 20) begin
         @(posedge axi_aclk);
         if (in_xfer) begin
            void'(in_data.pop_front());
            void'(in_last.pop_front());
         end
         if (in_data.size() > 0) begin
            s_axis_tvalid <= 1'b1;
            s_axis_tdata  <= in_data[0];
            s_axis_tlast  <= in_last[0];
         end else begin
            s_axis_tvalid <= 1'b0;
         end
         if (exp_data.size() > 0 && tbl_bp[exp_idx[0]]) begin
            lcg_state = lcg_next(lcg_state);
            m_axis_tready <= lcg_state[16];
         end else begin
            m_axis_tready <= 1'b1;
         end

         @(negedge axi_aclk);
         in_xfer = s_axis_tvalid & s_axis_tready;
         if (m_axis_tvalid && m_axis_tready) begin
            if (exp_data.size() == 0) begin
               $display("unexpected output word %h after the last expected word",
                        m_axis_tdata);
               other_errors++;
            end else begin
               name = $sformatf("%s word %0d", test_name[exp_idx[0]], exp_pos[0]);
               check_data(name, exp_data[0], m_axis_tdata);
               check_last(name, exp_last[0], m_axis_tlast);
               void'(exp_data.pop_front());
               void'(exp_last.pop_front());
               void'(exp_idx.pop_front());
               void'(exp_pos.pop_front());
            end
         end
         if (!s_axis_tready) full_cycles++;
         if (exp_data.size() == 0) drain++;
         cycles++;
         if (cycles >= limit) timed_out = 1'b1;
      end

      if (timed_out) begin
         $display("timeout: output stalled after %0d cycles, %0d words still expected",
                  cycles, exp_data.size());
         other_errors++;
      end
      if (in_data.size() != 0) begin
         $display("%0d input words were never accepted", in_data.size());
         other_errors++;
      end
      if (full_cycles == 0) begin
         $display("s_axis_tready never went low, the input FIFO never filled");
         other_errors++;
      end
      $display("errors: %0d check failures, %0d other failures", check_errors, other_errors);
      if (check_errors == 0 && other_errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: ualink_turbo.f
+incdir+source
source/ualink_pkg.sv
source/ualink_stream_if.sv
source/ualink_rx_fifo.sv
source/ualink_data_mem.sv
source/ualink_cmd_parser.sv
source/ualink_rsp_gen.sv
source/ualink_turbo.sv
testbench/ualink_turbo_tb.sv

// File: Makefile
# Verilator build, run and lint for the UALink turbo design

VERILATOR  ?= verilator
TOP        ?= ualink_turbo_tb
RTL_TOP    ?= ualink_turbo
FILELIST   ?= ualink_turbo.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF -- '** PASS **'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
